// File: hdl/arith_settings.svh
// Word width must be 4 or more; multiplier latency is fixed at 2 and a zero divisor is undefined
`ifndef ARITH_SETTINGS_SVH
`define ARITH_SETTINGS_SVH

// Operand and result width in bits
`define ARITH_WIDTH 32

// Cycles from mul_go to mul_done
// The multiplier has exactly two register stages, so this stays at 2
`define ARITH_MULT_LATENCY 2

`endif

// File: hdl/arith_pkg.sv
// Shared types for the arithmetic unit; widths follow ARITH_WIDTH from the settings header
`include "arith_settings.svh"

package arith_pkg;

  // One operand or result word, always unsigned
  typedef logic [`ARITH_WIDTH-1:0] word_t;

  // Operand word read either as unsigned or as two's complement
  typedef union packed {
    logic        [`ARITH_WIDTH-1:0] u;
    logic signed [`ARITH_WIDTH-1:0] s;
  } operand_u;

  // Divider iteration counter, wide enough to hold ARITH_WIDTH itself
  typedef logic [$clog2(`ARITH_WIDTH):0] count_t;

endpackage

// File: hdl/mult_pipe.sv
// Low word of a*b, same for signed and unsigned; done exactly 2 cycles after go, no back-pressure
`timescale 1ns/10ps
`include "arith_settings.svh"

module mult_pipe (
  input  logic             clk,
  input  logic             reset,
  input  logic             go,
  input  arith_pkg::word_t a,
  input  arith_pkg::word_t b,
  output arith_pkg::word_t product,
  output logic             done
);

  arith_pkg::word_t a_q;
  arith_pkg::word_t b_q;

  // One valid bit per pipeline stage, so back-to-back starts each get a done
  logic [`ARITH_MULT_LATENCY-1:0] valid_sr;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_sr <= '0;
    end else begin
      valid_sr <= {valid_sr[`ARITH_MULT_LATENCY-2:0], go};
    end
  end

  // Stage 1 captures the operands
  always_ff @(posedge clk) begin
    if (go) begin
      a_q <= a;
      b_q <= b;
    end
  end

  // Stage 2 keeps only the low word of the product
  always_ff @(posedge clk) begin
    if (valid_sr[0]) begin
      product <= a_q * b_q;
    end
  end

  assign done = valid_sr[`ARITH_MULT_LATENCY-1];

  // Nothing in flight may survive reset
  a_no_done_after_reset: assert property (
    @(posedge clk) reset |=> !done
  ) else $error("mult_pipe: done raised in the cycle after reset");

endmodule

// File: hdl/div_core.sv
// Unsigned divider; one op at a time, done after 1 cycle for a zero dividend else WIDTH+1
`timescale 1ns/10ps
`include "arith_settings.svh"

module div_core (
  input  logic             clk,
  input  logic             reset,
  input  logic             go,
  input  arith_pkg::word_t dividend,
  input  arith_pkg::word_t divisor,
  output arith_pkg::word_t quotient,
  output arith_pkg::word_t remainder,
  output logic             busy,
  output logic             done
);

  arith_pkg::word_t  rem_q;
  arith_pkg::word_t  quo_q;
  arith_pkg::word_t  mask_q;
  arith_pkg::count_t count_q;

  // Divisor aligned under the top dividend bit, shifted right each step
  logic [2*`ARITH_WIDTH-2:0] div_sh;

  logic start;
  logic finished;
  logic step;
  logic fits;

  assign start    = go && !busy;
  assign finished = busy && (mask_q == '0);
  assign step     = busy && !finished;
  assign fits     = div_sh <= {{(`ARITH_WIDTH-1){1'b0}}, rem_q};

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (start) begin
      // A zero dividend finishes at once and never goes busy
      busy <= dividend != '0;
    end else if (finished) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else begin
      done <= finished || (start && dividend == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mask_q  <= '0;
      count_q <= '0;
    end else if (start) begin
      mask_q  <= {1'b1, {(`ARITH_WIDTH-1){1'b0}}};
      count_q <= '0;
    end else if (step) begin
      mask_q  <= mask_q >> 1;
      count_q <= count_q + 1'b1;
    end
  end

  // Restoring step: subtract where the shifted divisor fits
  always_ff @(posedge clk) begin
    if (start) begin
      rem_q  <= dividend;
      quo_q  <= '0;
      div_sh <= {divisor, {(`ARITH_WIDTH-1){1'b0}}};
    end else if (step) begin
      if (fits) begin
        rem_q <= rem_q - div_sh[`ARITH_WIDTH-1:0];
        quo_q <= quo_q | mask_q;
      end
      div_sh <= div_sh >> 1;
    end
  end

  // Results are cleared on a start and loaded when the mask runs out
  always_ff @(posedge clk) begin
    if (start) begin
      quotient  <= '0;
      remainder <= '0;
    end else if (finished) begin
      quotient  <= quo_q;
      remainder <= rem_q;
    end
  end

  a_done_follows_work: assert property (
    @(posedge clk) disable iff (reset) done |-> $past(busy || start)
  ) else $error("div_core: done without a preceding start or busy cycle");

  a_count_bound: assert property (
    @(posedge clk) disable iff (reset) count_q <= arith_pkg::count_t'(`ARITH_WIDTH)
  ) else $error("div_core: iteration count ran past the word width");

endmodule

// File: hdl/signed_div.sv
// Signed or unsigned division chosen per start; results valid with done and held until next start
`timescale 1ns/10ps

module signed_div (
  input  logic             clk,
  input  logic             reset,
  input  logic             go,
  input  logic             is_signed,
  input  arith_pkg::word_t a,
  input  arith_pkg::word_t b,
  output arith_pkg::word_t quotient,
  output arith_pkg::word_t remainder,
  output logic             busy,
  output logic             done
);

  arith_pkg::operand_u a_op;
  arith_pkg::operand_u b_op;

  logic a_neg;
  logic b_neg;

  arith_pkg::word_t a_mag;
  arith_pkg::word_t b_mag;
  arith_pkg::word_t core_quo;
  arith_pkg::word_t core_rem;
  arith_pkg::word_t b_mag_q;
  arith_pkg::word_t t1;

  logic mode_q;
  logic a_sign_q;
  logic b_sign_q;
  logic diff_signs;

  assign a_op.u = a;
  assign b_op.u = b;

  // Magnitudes only in signed mode; the most negative value maps to itself unsigned
  assign a_neg = is_signed && (a_op.s < 0);
  assign b_neg = is_signed && (b_op.s < 0);
  assign a_mag = a_neg ? -a_op.u : a_op.u;
  assign b_mag = b_neg ? -b_op.u : b_op.u;

  // Capture on the same condition div_core accepts on
  always_ff @(posedge clk) begin
    if (reset) begin
      mode_q   <= 1'b0;
      a_sign_q <= 1'b0;
      b_sign_q <= 1'b0;
    end else if (go && !busy) begin
      mode_q   <= is_signed;
      a_sign_q <= a_op.s < 0;
      b_sign_q <= b_op.s < 0;
    end
  end

  always_ff @(posedge clk) begin
    if (go && !busy) begin
      b_mag_q <= b_mag;
    end
  end

  div_core core0 (
    .clk      (clk),
    .reset    (reset),
    .go       (go),
    .dividend (a_mag),
    .divisor  (b_mag),
    .quotient (core_quo),
    .remainder(core_rem),
    .busy     (busy),
    .done     (done)
  );

  assign diff_signs = mode_q && (a_sign_q ^ b_sign_q);

  // Quotient truncates toward zero
  assign quotient = diff_signs ? -core_quo : core_quo;

  // Remainder takes the sign of the divisor
  assign t1        = (diff_signs && core_rem != '0) ? b_mag_q - core_rem : core_rem;
  assign remainder = (mode_q && b_sign_q) ? -t1 : t1;

endmodule

// File: hdl/arith_unit.sv
// Multiplier and divider run independently on shared operands; take results while done is high
`timescale 1ns/10ps

module arith_unit (
  input  logic             clk,
  input  logic             reset,
  input  logic             mul_go,
  input  logic             div_go,
  input  logic             div_signed,
  input  arith_pkg::word_t a,
  input  arith_pkg::word_t b,
  output arith_pkg::word_t product,
  output arith_pkg::word_t quotient,
  output arith_pkg::word_t remainder,
  output logic             mul_done,
  output logic             div_done,
  output logic             div_busy
);

  mult_pipe mult0 (
    .clk    (clk),
    .reset  (reset),
    .go     (mul_go),
    .a      (a),
    .b      (b),
    .product(product),
    .done   (mul_done)
  );

  // A div_go while div_busy is high is dropped inside the divider
  signed_div div0 (
    .clk      (clk),
    .reset    (reset),
    .go       (div_go),
    .is_signed(div_signed),
    .a        (a),
    .b        (b),
    .quotient (quotient),
    .remainder(remainder),
    .busy     (div_busy),
    .done     (div_done)
  );

endmodule

// File: verif/arith_checks.svh
// Compare tasks included inside arith_unit_tb; each one ends the run at its first mismatch
`ifndef ARITH_CHECKS_SVH
`define ARITH_CHECKS_SVH

  // Low word of the product
  task automatic check_product(input arith_pkg::word_t got, input arith_pkg::word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at %0t: product is %h, expected %h", $time, got, exp));
    end
  endtask

  // Quotient and remainder of the division that just finished
  task automatic check_div(input arith_pkg::word_t got_q, input arith_pkg::word_t got_r,
                           input arith_pkg::word_t exp_q, input arith_pkg::word_t exp_r);
    if (got_q !== exp_q || got_r !== exp_r) begin
      abort_run($sformatf("FAIL at %0t: %h / %h (signed %b) gave q=%h r=%h, expected q=%h r=%h",
                          $time, div_a, div_b, div_sgn, got_q, got_r, exp_q, exp_r));
    end
  endtask

  // Handshake bits such as mul_done, div_done and div_busy
  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      abort_run($sformatf("FAIL at %0t: %s is %b, expected %b", $time, name, got, exp));
    end
  endtask

`endif

// File: verif/arith_unit_tb.sv
// Random operands from a fixed seed; zero divisors are never sent since their result is undefined
`timescale 1ns/10ps
`include "arith_settings.svh"

module arith_unit_tb;

  localparam int W            = `ARITH_WIDTH;
  localparam int RESET_CYCLES = 8;
  localparam int N_MUL        = 40;
  localparam int N_UDIV       = 20;
  localparam int N_SDIV       = 6;
  localparam int N_CORNER     = 3;
  localparam int N_ZERO       = 4;
  localparam int N_BUSY       = 3;
  localparam int N_OPS = N_MUL + N_UDIV + 4 * N_SDIV + N_CORNER + N_ZERO + 2 * N_BUSY + 4;

  logic             clk;
  logic             reset;
  logic             mul_go;
  logic             div_go;
  logic             div_signed;
  arith_pkg::word_t a;
  arith_pkg::word_t b;
  arith_pkg::word_t product;
  arith_pkg::word_t quotient;
  arith_pkg::word_t remainder;
  logic             mul_done;
  logic             div_done;
  logic             div_busy;

  // Model state and the count of rising edges
  int unsigned      cyc;
  logic [31:0]      rng_state;
  arith_pkg::word_t prod_q[$];
  int unsigned      prod_due_q[$];
  logic             div_pending;
  int unsigned      div_start;
  int unsigned      div_due;
  arith_pkg::word_t exp_quo;
  arith_pkg::word_t exp_rem;
  arith_pkg::word_t div_a;
  arith_pkg::word_t div_b;
  logic             div_sgn;

  arith_unit dut0 (
    .clk       (clk),
    .reset     (reset),
    .mul_go    (mul_go),
    .div_go    (div_go),
    .div_signed(div_signed),
    .a         (a),
    .b         (b),
    .product   (product),
    .quotient  (quotient),
    .remainder (remainder),
    .mul_done  (mul_done),
    .div_done  (div_done),
    .div_busy  (div_busy)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  `include "arith_checks.svh"

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic arith_pkg::word_t rand_word();
    logic [63:0] wide;
    wide = {next_rand(), next_rand()};
    return wide[W-1:0];
  endfunction

  function automatic arith_pkg::word_t nonzero(input arith_pkg::word_t v);
    return (v == '0) ? arith_pkg::word_t'(1) : v;
  endfunction

  // Random shift gives divisors of every size, so quotients vary
  function automatic arith_pkg::word_t rand_divisor();
    return nonzero(rand_word() >> (next_rand() % W));
  endfunction

  function automatic arith_pkg::word_t with_sign(input logic neg, input arith_pkg::word_t mag);
    return neg ? -mag : mag;
  endfunction

  // Magnitude division, quotient negated on differing signs, remainder follows the divisor
  function automatic void div_model(input arith_pkg::word_t av, input arith_pkg::word_t bv,
                                    input logic sgn, output arith_pkg::word_t q,
                                    output arith_pkg::word_t r);
    arith_pkg::operand_u ao;
    arith_pkg::operand_u bo;
    arith_pkg::word_t    am;
    arith_pkg::word_t    bm;
    arith_pkg::word_t    q0;
    arith_pkg::word_t    t0;
    arith_pkg::word_t    t1;
    logic                an;
    logic                bn;
    ao.u = av;
    bo.u = bv;
    an   = sgn && (ao.s < 0);
    bn   = sgn && (bo.s < 0);
    am   = an ? -ao.u : ao.u;
    bm   = bn ? -bo.u : bo.u;
    q0   = am / bm;
    t0   = am % bm;
    t1   = (an != bn && t0 != '0) ? bm - t0 : t0;
    q    = (an != bn) ? -q0 : q0;
    r    = bn ? -t1 : t1;
  endfunction

  // Sample outputs 1 ns after each rising edge and compare them with the model
  task automatic tick();
    logic mul_exp;
    logic div_exp;
    logic busy_exp;
    @(posedge clk);
    #1;
    cyc++;
    mul_go   = 1'b0;
    div_go   = 1'b0;
    mul_exp  = (prod_due_q.size() > 0) && (prod_due_q[0] == cyc);
    div_exp  = div_pending && (div_due == cyc);
    busy_exp = div_pending && (cyc > div_start) && (cyc < div_due);
    check_flag(mul_done, mul_exp, "mul_done");
    check_flag(div_done, div_exp, "div_done");
    check_flag(div_busy, busy_exp, "div_busy");
    if (mul_exp) begin
      check_product(product, prod_q.pop_front());
      void'(prod_due_q.pop_front());
    end
    if (div_exp) begin
      check_div(quotient, remainder, exp_quo, exp_rem);
      div_pending = 1'b0;
    end
  endtask

  task automatic apply(input logic do_mul, input logic do_div, input logic sgn,
                       input arith_pkg::word_t av, input arith_pkg::word_t bv);
    arith_pkg::word_t p;
    mul_go     = do_mul;
    div_go     = do_div;
    div_signed = sgn;
    a          = av;
    b          = bv;
    if (do_mul) begin
      p = av * bv;
      prod_q.push_back(p);
      prod_due_q.push_back(cyc + `ARITH_MULT_LATENCY);
    end
    // A strobe while a division is in flight is dropped
    if (do_div && !div_pending) begin
      div_model(av, bv, sgn, exp_quo, exp_rem);
      div_a       = av;
      div_b       = bv;
      div_sgn     = sgn;
      div_pending = 1'b1;
      div_start   = cyc;
      // Accepted at the next edge; a zero dividend is done there, else W+1 cycles later
      div_due     = (av == '0) ? cyc + 1 : cyc + W + 2;
    end
  endtask

  task automatic wait_idle();
    while (div_pending || prod_q.size() > 0) tick();
  endtask

  task automatic run_div(input arith_pkg::word_t av, input arith_pkg::word_t bv,
                         input logic sgn);
    apply(1'b0, 1'b1, sgn, av, bv);
    wait_idle();
  endtask

  initial begin
    repeat (RESET_CYCLES + N_OPS * (W + 4)) @(posedge clk);
    abort_run($sformatf("Timeout: the test did not finish within %0d cycles",
                        RESET_CYCLES + N_OPS * (W + 4)));
  end

  initial begin
    int unsigned      i;
    int unsigned      k;
    arith_pkg::word_t av;
    arith_pkg::word_t bv;
    rng_state   = 32'h0f24_ea63;
    cyc         = 0;
    reset       = 1'b1;
    mul_go      = 1'b0;
    div_go      = 1'b0;
    div_signed  = 1'b0;
    a           = '0;
    b           = '0;
    div_pending = 1'b0;
    div_start   = 0;
    div_due     = 0;
    exp_quo     = '0;
    exp_rem     = '0;
    div_a       = '0;
    div_b       = '0;
    div_sgn     = 1'b0;
    repeat (RESET_CYCLES) tick();
    reset = 1'b0;
    repeat (4) tick();
    for (i = 0; i < N_MUL; i++) begin
      av = rand_word();
      bv = rand_word();
      apply(1'b1, 1'b0, 1'b0, av, bv);
      tick();
    end
    wait_idle();
    for (i = 0; i < N_UDIV; i++) begin
      av = rand_word();
      bv = rand_divisor();
      run_div(av, bv, 1'b0);
    end
    // k[1] is the dividend sign, k[0] the divisor sign
    for (k = 0; k < 4; k++) begin
      for (i = 0; i < N_SDIV; i++) begin
        av = with_sign(k[1], rand_word() >> 1);
        bv = with_sign(k[0], nonzero(rand_divisor() >> 1));
        run_div(av, bv, 1'b1);
      end
    end
    run_div({1'b1, {(W-1){1'b0}}}, '1, 1'b1);
    run_div(arith_pkg::word_t'(-7), arith_pkg::word_t'(2), 1'b1);
    run_div(arith_pkg::word_t'(7), arith_pkg::word_t'(-2), 1'b1);
    for (i = 0; i < N_ZERO; i++) begin
      run_div('0, rand_divisor(), i[0]);
    end
    // Products keep flowing while the divider is busy and ignores a second strobe
    for (i = 0; i < N_BUSY; i++) begin
      av = nonzero(rand_word());
      bv = rand_divisor();
      apply(1'b1, 1'b1, i[0], av, bv);
      k = 0;
      tick();
      while (div_pending) begin
        av = rand_word();
        bv = rand_divisor();
        apply(1'b1, k == 3, ~i[0], av, bv);
        k++;
        tick();
      end
      wait_idle();
    end
    repeat (4) tick();
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: arith_unit.f
+incdir+hdl
+incdir+verif
hdl/arith_pkg.sv
hdl/mult_pipe.sv
hdl/div_core.sv
hdl/signed_div.sv
hdl/arith_unit.sv
verif/arith_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the arithmetic unit testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  -f arith_unit.f --top-module arith_unit_tb -o arith_sim \
  && ./obj_dir/arith_sim > sim.log 2>&1
test -f sim.log && cat sim.log
test -f sim.log || { echo "Simulation did not run"; exit 1; }
grep -q "ERRORS FOUND" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
exit 0
